//--- gnss_fe_pkg.sv
package gnss_fe_pkg;

  // ==============================
  // Timing
  // ==============================
  localparam int UART_CLKS_PER_BIT = 16;  // Real 115200 baud build uses 1736
  localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT + 1);
  localparam logic [UART_CNT_W-1:0] UART_BIT_LAST = UART_CNT_W'(UART_CLKS_PER_BIT - 1);
  localparam logic [UART_CNT_W-1:0] UART_BIT_MID  = UART_CNT_W'(UART_CLKS_PER_BIT / 2 - 1);

  localparam int SPI_HALF_PERIOD = 4;  // CLK_200 cycles per SPI half period
  localparam int SPI_CNT_W       = $clog2(SPI_HALF_PERIOD + 1);
  localparam logic [SPI_CNT_W-1:0] SPI_HALF_LAST = SPI_CNT_W'(SPI_HALF_PERIOD - 1);

  // ==============================
  // Command set
  // ==============================
  localparam logic [7:0] CMD_VERSION = 8'h11;
  localparam logic [7:0] CMD_SPI     = 8'h55;
  localparam logic [7:0] SUB_SPI_WR  = 8'h01;
  localparam logic [7:0] SUB_SPI_RD  = 8'h02;
  localparam logic [7:0] REPLY_HDR   = 8'hAA;  // First byte of SPI acknowledge

  localparam int VERSION_LEN = 12;
  localparam logic [0:VERSION_LEN-1][7:0] version_str = "NT1065_us_v5";  // Index 0 is 'N'

  localparam logic [15:0] CRC_INIT = 16'hFFFF;

  // ==============================
  // Types
  // ==============================
  typedef struct packed {
    logic       is_read;  // Frame MSB
    logic [6:0] addr;
    logic [7:0] wdata;    // Zero on reads
  } spi_cmd_t;

  typedef enum logic {
    REPLY_VERSION = 1'b0,
    REPLY_SPI_ACK = 1'b1
  } reply_kind_t;

  // CRC-16/CCITT-FALSE byte update with poly 0x1021
  function automatic logic [15:0] crc16_update(input logic [15:0] crc,
                                               input logic [7:0]  data);
    logic [15:0] x;
    x = {8'h00, crc[15:8] ^ data};
    x = x ^ (x >> 4);
    return (crc << 8) ^ (x << 12) ^ (x << 5) ^ x;
  endfunction

endpackage

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
  input  logic       CLK_200,
  input  logic       glbl_rst,
  input  logic       rx_line,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t                          state;
  logic [1:0]                         sync_q;    // Line synchronizer
  logic                               rx_s;
  logic [gnss_fe_pkg::UART_CNT_W-1:0] baud_cnt;
  logic [2:0]                         bit_cnt;
  logic [7:0]                         shreg;

  assign rx_s    = sync_q[1];
  assign rx_byte = shreg;

  always_ff @(posedge CLK_200)
  begin
    if (glbl_rst)
    begin
      sync_q   <= 2'b11;  // Idle line level
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      sync_q   <= {sync_q[0], rx_line};
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE:
        begin
          baud_cnt <= '0;
          if (!rx_s)
            state <= RX_START;  // Falling edge seen
        end
        RX_START:
        begin
          if (baud_cnt == gnss_fe_pkg::UART_BIT_MID)
          begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_s ? RX_IDLE : RX_DATA;  // Reject short glitches
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        RX_DATA:
        begin
          if (baud_cnt == gnss_fe_pkg::UART_BIT_LAST)
          begin
            baud_cnt <= '0;
            shreg    <= {rx_s, shreg[7:1]};  // LSB arrives first
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7)
              state <= RX_STOP;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        default:
        begin
          if (baud_cnt == gnss_fe_pkg::UART_BIT_LAST)
          begin
            rx_valid <= rx_s;  // Framing error drops the byte
            state    <= RX_IDLE;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
      endcase
    end
  end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
  input  logic       CLK_200,
  input  logic       glbl_rst,
  input  logic [7:0] tx_byte,
  input  logic       tx_start,
  output logic       tx_line,
  output logic       tx_busy
);

  logic [9:0]                         shreg;     // Stop, data, start
  logic [gnss_fe_pkg::UART_CNT_W-1:0] baud_cnt;
  logic [3:0]                         bit_cnt;

  assign tx_line = shreg[0];

  always_ff @(posedge CLK_200)
  begin
    if (glbl_rst)
    begin
      shreg    <= '1;  // Line idles high
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx_busy  <= 1'b0;
    end
    else if (!tx_busy)
    begin
      baud_cnt <= '0;
      bit_cnt  <= '0;
      if (tx_start)
      begin
        shreg   <= {1'b1, tx_byte, 1'b0};
        tx_busy <= 1'b1;
      end
    end
    else if (baud_cnt == gnss_fe_pkg::UART_BIT_LAST)
    begin
      baud_cnt <= '0;
      shreg    <= {1'b1, shreg[9:1]};  // Ones fill behind the stop bit
      if (bit_cnt == 4'd9)
        tx_busy <= 1'b0;  // Stop bit done
      else
        bit_cnt <= bit_cnt + 1'b1;
    end
    else
      baud_cnt <= baud_cnt + 1'b1;
  end

endmodule

//--- spi_master.sv
`timescale 1ns/1ps

module spi_master (
  input  logic                  CLK_200,
  input  logic                  glbl_rst,
  input  gnss_fe_pkg::spi_cmd_t spi_cmd,
  input  logic                  spi_start,
  input  logic                  spi_miso,
  output logic [7:0]            spi_rdata,
  output logic                  spi_busy,
  output logic                  spi_done,
  output logic                  spi_ss,
  output logic                  spi_clk,
  output logic                  spi_mosi
);

  logic [15:0]                       tx_sh;
  logic [7:0]                        rx_sh;     // Keeps the last 8 MISO bits
  logic [gnss_fe_pkg::SPI_CNT_W-1:0] half_cnt;
  logic [5:0]                        edge_cnt;  // 32 clock edges per frame
  logic                              ending;

  always_ff @(posedge CLK_200)
  begin
    if (glbl_rst)
    begin
      spi_busy <= 1'b0;
      spi_done <= 1'b0;
      spi_ss   <= 1'b1;
      spi_clk  <= 1'b0;
      spi_mosi <= 1'b0;
      half_cnt <= '0;
      edge_cnt <= '0;
      ending   <= 1'b0;
    end
    else
    begin
      spi_done <= 1'b0;
      if (!spi_busy)
      begin
        if (spi_start)
        begin
          tx_sh    <= spi_cmd;
          spi_mosi <= spi_cmd.is_read;  // First bit ready before first rise
          spi_ss   <= 1'b0;
          spi_busy <= 1'b1;
          half_cnt <= '0;
          edge_cnt <= '0;
          ending   <= 1'b0;
        end
      end
      else if (ending)
      begin
        spi_ss    <= 1'b1;
        spi_busy  <= 1'b0;
        spi_done  <= 1'b1;
        spi_mosi  <= 1'b0;
        spi_rdata <= rx_sh;
        ending    <= 1'b0;
      end
      else if (half_cnt == gnss_fe_pkg::SPI_HALF_LAST)
      begin
        half_cnt <= '0;
        spi_clk  <= ~spi_clk;
        edge_cnt <= edge_cnt + 1'b1;
        if (!spi_clk)
          rx_sh <= {rx_sh[6:0], spi_miso};  // Rising edge
        else
        begin
          tx_sh    <= {tx_sh[14:0], 1'b0};  // Falling edge
          spi_mosi <= tx_sh[14];
          if (edge_cnt == 6'd31)
            ending <= 1'b1;
        end
      end
      else
        half_cnt <= half_cnt + 1'b1;
    end
  end

endmodule

//--- fe_cmd_ctrl.sv
`timescale 1ns/1ps

module fe_cmd_ctrl (
  input  logic                     CLK_200,
  input  logic                     glbl_rst,
  input  logic [7:0]               rx_byte,
  input  logic                     rx_valid,
  input  logic                     spi_busy,
  input  logic                     spi_done,
  input  logic [7:0]               spi_rdata,
  input  logic                     reply_busy,
  output gnss_fe_pkg::spi_cmd_t    spi_cmd,
  output logic                     spi_start,
  output logic                     reply_start,
  output gnss_fe_pkg::reply_kind_t reply_kind,
  output logic [7:0]               reply_data,
  output logic                     crc_err
);

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_SUB,
    ST_ADDR,
    ST_DATA,
    ST_CRC_H,
    ST_CRC_L,
    ST_CMP,
    ST_SPI_WAIT,
    ST_REPLY_WAIT
  } ctrl_state_t;

  ctrl_state_t state;
  logic [15:0] crc_run;    // CRC over bytes seen so far
  logic [15:0] crc_rx;     // CRC sent by the host
  logic        busy_seen;  // Reply has actually started

  // ==============================
  // Main FSM
  // ==============================
  always_ff @(posedge CLK_200)
  begin
    if (glbl_rst)
    begin
      state       <= ST_IDLE;
      spi_start   <= 1'b0;
      reply_start <= 1'b0;
      crc_err     <= 1'b0;
      busy_seen   <= 1'b0;
    end
    else
    begin
      spi_start   <= 1'b0;
      reply_start <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          busy_seen <= 1'b0;
          if (rx_valid)
          begin
            if (rx_byte == gnss_fe_pkg::CMD_VERSION)
            begin
              reply_kind  <= gnss_fe_pkg::REPLY_VERSION;
              reply_start <= 1'b1;
              state       <= ST_REPLY_WAIT;
            end
            else if (rx_byte == gnss_fe_pkg::CMD_SPI)
            begin
              crc_run <= gnss_fe_pkg::crc16_update(gnss_fe_pkg::CRC_INIT,
                                                   gnss_fe_pkg::CMD_SPI);
              state   <= ST_SUB;
            end
          end
        end
        ST_SUB:
        begin
          if (rx_valid)
          begin
            crc_run       <= gnss_fe_pkg::crc16_update(crc_run, rx_byte);
            spi_cmd.wdata <= 8'h00;  // Stays zero for reads
            case (rx_byte)
              gnss_fe_pkg::SUB_SPI_WR:
              begin
                spi_cmd.is_read <= 1'b0;
                state           <= ST_ADDR;
              end
              gnss_fe_pkg::SUB_SPI_RD:
              begin
                spi_cmd.is_read <= 1'b1;
                state           <= ST_ADDR;
              end
              default:
                state <= ST_IDLE;  // Unknown sub-command
            endcase
          end
        end
        ST_ADDR:
        begin
          if (rx_valid)
          begin
            spi_cmd.addr <= rx_byte[6:0];
            crc_run      <= gnss_fe_pkg::crc16_update(crc_run, rx_byte);
            state        <= spi_cmd.is_read ? ST_CRC_H : ST_DATA;
          end
        end
        ST_DATA:
        begin
          if (rx_valid)
          begin
            spi_cmd.wdata <= rx_byte;
            crc_run       <= gnss_fe_pkg::crc16_update(crc_run, rx_byte);
            state         <= ST_CRC_H;
          end
        end
        ST_CRC_H:
        begin
          if (rx_valid)
          begin
            crc_rx[15:8] <= rx_byte;
            state        <= ST_CRC_L;
          end
        end
        ST_CRC_L:
        begin
          if (rx_valid)
          begin
            crc_rx[7:0] <= rx_byte;
            state       <= ST_CMP;
          end
        end
        ST_CMP:
        begin
          if (crc_run != crc_rx)
          begin
            crc_err <= 1'b1;  // No frame, no reply
            state   <= ST_IDLE;
          end
          else if (!spi_busy)
          begin
            crc_err   <= 1'b0;
            spi_start <= 1'b1;
            state     <= ST_SPI_WAIT;
          end
        end
        ST_SPI_WAIT:
        begin
          if (spi_done)
          begin
            reply_data  <= spi_rdata;
            reply_kind  <= gnss_fe_pkg::REPLY_SPI_ACK;
            reply_start <= 1'b1;
            state       <= ST_REPLY_WAIT;
          end
        end
        ST_REPLY_WAIT:
        begin
          if (reply_busy)
            busy_seen <= 1'b1;
          else if (busy_seen)
            state <= ST_IDLE;  // Last stop bit sent
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- reply_sender.sv
`timescale 1ns/1ps

module reply_sender (
  input  logic                     CLK_200,
  input  logic                     glbl_rst,
  input  logic                     reply_start,
  input  gnss_fe_pkg::reply_kind_t reply_kind,
  input  logic [7:0]               reply_data,
  input  logic                     tx_busy,
  output logic                     reply_busy,
  output logic [7:0]               tx_byte,
  output logic                     tx_start
);

  typedef enum logic [1:0] {PH_ISSUE, PH_ARM, PH_WAIT} tx_phase_t;

  tx_phase_t                phase;
  gnss_fe_pkg::reply_kind_t kind_q;
  logic [7:0]               data_q;
  logic [3:0]               idx;      // Byte being sent
  logic [3:0]               len;
  logic [15:0]              ack_crc;

  assign ack_crc = gnss_fe_pkg::crc16_update(
                     gnss_fe_pkg::crc16_update(gnss_fe_pkg::CRC_INIT, gnss_fe_pkg::REPLY_HDR),
                     data_q);

  // Byte select
  always_comb
  begin
    if (kind_q == gnss_fe_pkg::REPLY_VERSION)
      tx_byte = gnss_fe_pkg::version_str[idx];
    else
    begin
      case (idx[1:0])
        2'd0:    tx_byte = gnss_fe_pkg::REPLY_HDR;
        2'd1:    tx_byte = data_q;
        2'd2:    tx_byte = ack_crc[15:8];
        default: tx_byte = ack_crc[7:0];
      endcase
    end
  end

  always_ff @(posedge CLK_200)
  begin
    if (glbl_rst)
    begin
      reply_busy <= 1'b0;
      tx_start   <= 1'b0;
      phase      <= PH_ISSUE;
      idx        <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      if (!reply_busy)
      begin
        if (reply_start)
        begin
          kind_q     <= reply_kind;
          data_q     <= reply_data;
          len        <= (reply_kind == gnss_fe_pkg::REPLY_VERSION) ?
                        4'(gnss_fe_pkg::VERSION_LEN) : 4'd4;
          idx        <= '0;
          phase      <= PH_ISSUE;
          reply_busy <= 1'b1;
        end
      end
      else
      begin
        case (phase)
          PH_ISSUE:
          begin
            if (!tx_busy)
            begin
              tx_start <= 1'b1;
              phase    <= PH_ARM;
            end
          end
          PH_ARM:
            phase <= PH_WAIT;  // tx_busy rises here
          default:
          begin
            if (!tx_busy)
            begin
              if (idx == len - 4'd1)
                reply_busy <= 1'b0;
              else
                idx <= idx + 1'b1;
              phase <= PH_ISSUE;
            end
          end
        endcase
      end
    end
  end

endmodule

//--- gnss_fe_top.sv
`timescale 1ns/1ps

module gnss_fe_top (
  input  logic CLK_200,
  input  logic glbl_rst,
  input  logic uart_rx_line,
  input  logic spi_miso,
  output logic uart_tx_line,
  output logic spi_ss,
  output logic spi_clk,
  output logic spi_mosi,
  output logic crc_err
);

  logic [7:0]               rx_byte;
  logic                     rx_valid;
  gnss_fe_pkg::spi_cmd_t    spi_cmd;
  logic                     spi_start;
  logic                     spi_busy;
  logic                     spi_done;
  logic [7:0]               spi_rdata;
  logic                     reply_start;
  gnss_fe_pkg::reply_kind_t reply_kind;
  logic [7:0]               reply_data;
  logic                     reply_busy;
  logic [7:0]               tx_byte;
  logic                     tx_start;
  logic                     tx_busy;

  // ==============================
  // Host UART
  // ==============================
  uart_rx u_uart_rx (
    .CLK_200  (CLK_200),
    .glbl_rst (glbl_rst),
    .rx_line  (uart_rx_line),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  uart_tx u_uart_tx (
    .CLK_200  (CLK_200),
    .glbl_rst (glbl_rst),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx_line  (uart_tx_line),
    .tx_busy  (tx_busy)
  );

  // ==============================
  // Control and SPI
  // ==============================
  fe_cmd_ctrl u_ctrl (
    .CLK_200     (CLK_200),
    .glbl_rst    (glbl_rst),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .spi_busy    (spi_busy),
    .spi_done    (spi_done),
    .spi_rdata   (spi_rdata),
    .reply_busy  (reply_busy),
    .spi_cmd     (spi_cmd),
    .spi_start   (spi_start),
    .reply_start (reply_start),
    .reply_kind  (reply_kind),
    .reply_data  (reply_data),
    .crc_err     (crc_err)
  );

  spi_master u_spi (
    .CLK_200   (CLK_200),
    .glbl_rst  (glbl_rst),
    .spi_cmd   (spi_cmd),
    .spi_start (spi_start),
    .spi_miso  (spi_miso),
    .spi_rdata (spi_rdata),
    .spi_busy  (spi_busy),
    .spi_done  (spi_done),
    .spi_ss    (spi_ss),
    .spi_clk   (spi_clk),
    .spi_mosi  (spi_mosi)
  );

  reply_sender u_reply (
    .CLK_200     (CLK_200),
    .glbl_rst    (glbl_rst),
    .reply_start (reply_start),
    .reply_kind  (reply_kind),
    .reply_data  (reply_data),
    .tx_busy     (tx_busy),
    .reply_busy  (reply_busy),
    .tx_byte     (tx_byte),
    .tx_start    (tx_start)
  );

endmodule

//--- tb_frontend_models.sv
`timescale 1ns/1ps

module spi_reg_model (
  input  logic spi_ss,
  input  logic spi_clk,
  input  logic spi_mosi,
  output logic spi_miso
);

  logic [7:0]  regs [128];
  logic [15:0] frame   = 16'h0000;  // Bits shifted in from MOSI
  logic [7:0]  rd_sh   = 8'h00;     // Read data on its way out
  int          bit_cnt = 0;
  int          i;

  assign spi_miso = rd_sh[7];

  // Power-up contents of the front-end chip
  initial
  begin
    for (i = 0; i < 128; i++)
      regs[i] = i[7:0] ^ 8'h5A;
  end

  // ==============================
  // Capture on rising spi_clk
  // ==============================
  always @(posedge spi_clk or posedge spi_ss)
  begin
    if (spi_ss)
      bit_cnt = 0;  // Frame boundary
    else
    begin
      frame   = {frame[14:0], spi_mosi};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 16 && !frame[15])
        regs[frame[14:8]] = frame[7:0];  // Write completes on last bit
    end
  end

  // ==============================
  // Drive MISO on falling spi_clk
  // ==============================
  always @(negedge spi_clk or posedge spi_ss)
  begin
    if (spi_ss)
      rd_sh = 8'h00;
    else if (bit_cnt == 8)
    begin
      // Header is in and frame[7] is the read flag
      if (frame[7])
        rd_sh = regs[frame[6:0]];
      else
        rd_sh = 8'h00;  // Writes answer with zero
    end
    else
      rd_sh = {rd_sh[6:0], 1'b0};
  end

endmodule

//--- tb_gnss_fe.sv
`timescale 1ns/1ps

module tb_gnss_fe;

  localparam int          BIT_CLKS      = gnss_fe_pkg::UART_CLKS_PER_BIT;
  localparam int          BYTE_TIMEOUT  = 40 * BIT_CLKS;   // Gap between reply bytes
  localparam int          FIRST_TIMEOUT = 400 * BIT_CLKS;  // Command plus SPI frame
  localparam int          QUIET_CLKS    = 100 * BIT_CLKS;
  localparam logic [31:0] SEED          = 32'h1a800434;
  localparam logic [95:0] VERSION_ID    = "NT1065_us_v5";

  logic        CLK_200;
  logic        glbl_rst;
  logic        uart_rx_line;
  logic        spi_miso;
  logic        uart_tx_line;
  logic        spi_ss;
  logic        spi_clk;
  logic        spi_mosi;
  logic        crc_err;

  logic [7:0]  cmd_q [$];  // Host command bytes
  logic [7:0]  exp_q [$];  // Expected reply
  logic [7:0]  got_q [$];  // Reply as received
  logic [7:0]  shadow [128];
  logic        written [128];
  logic [31:0] rng;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          err_base;

  gnss_fe_top UUT (
    .CLK_200      (CLK_200),
    .glbl_rst     (glbl_rst),
    .uart_rx_line (uart_rx_line),
    .spi_miso     (spi_miso),
    .uart_tx_line (uart_tx_line),
    .spi_ss       (spi_ss),
    .spi_clk      (spi_clk),
    .spi_mosi     (spi_mosi),
    .crc_err      (crc_err)
  );

  spi_reg_model u_fe_chip (
    .spi_ss   (spi_ss),
    .spi_clk  (spi_clk),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso)
  );

  initial
  begin
    CLK_200 = 1'b0;
    forever
      #20 CLK_200 = ~CLK_200;
  end

  // ==============================
  // Reference models
  // ==============================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Bitwise CRC-16/CCITT-FALSE over the low nbytes of msg with the first byte highest
  function automatic logic [15:0] ref_crc16(input logic [31:0] msg, input int nbytes);
    logic [15:0] crc;
    logic        fb;
    int          i;
    crc = 16'hFFFF;
    for (i = nbytes * 8 - 1; i >= 0; i--)
    begin
      fb  = crc[15] ^ msg[i];
      crc = {crc[14:0], 1'b0};
      if (fb)
        crc = crc ^ 16'h1021;
    end
    return crc;
  endfunction

  // ==============================
  // Reporting
  // ==============================
  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, sig, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("** Failure at %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != err_base)
    begin
      tests_failed++;
      $display("[%0t ns] %-22s FAIL, %0d errors", $time, name, errors - err_base);
    end
    else
      $display("[%0t ns] %-22s ok", $time, name);
    err_base = errors;
  endtask

  // ==============================
  // Host UART
  // ==============================
  task automatic send_uart_byte(input logic [7:0] b);
    logic [9:0] bits;
    int         i;
    bits = {1'b1, b, 1'b0};  // Stop, data LSB first, start
    for (i = 0; i < 10; i++)
    begin
      @(posedge CLK_200);
      uart_rx_line <= bits[i];
      repeat (BIT_CLKS - 1) @(posedge CLK_200);
    end
  endtask

  task automatic send_command();
    int i;
    for (i = 0; i < cmd_q.size(); i++)
      send_uart_byte(cmd_q[i]);
  endtask

  task automatic receive_uart_byte(input int timeout, output logic [7:0] b, output bit ok);
    int n;
    int i;
    ok = 1'b0;
    b  = 8'h00;
    n  = 0;
    @(negedge CLK_200);
    while (uart_tx_line !== 1'b0 && n < timeout)
    begin
      @(negedge CLK_200);
      n++;
    end
    if (uart_tx_line !== 1'b0)
    begin
      report_problem($sformatf("no start bit on uart_tx_line within %0d cycles", timeout));
      return;
    end
    repeat (BIT_CLKS / 2) @(negedge CLK_200);  // Middle of start bit
    if (uart_tx_line !== 1'b0)
    begin
      report_problem("start bit on uart_tx_line ended early");
      return;
    end
    for (i = 0; i < 8; i++)
    begin
      repeat (BIT_CLKS) @(negedge CLK_200);
      b[i] = uart_tx_line;
    end
    repeat (BIT_CLKS) @(negedge CLK_200);
    if (uart_tx_line !== 1'b1)
    begin
      report_problem("stop bit on uart_tx_line is not high");
      return;
    end
    ok = 1'b1;
  endtask

  task automatic receive_reply(input int n);
    logic [7:0] b;
    bit         ok;
    int         k;
    got_q.delete();
    for (k = 0; k < n; k++)
    begin
      receive_uart_byte((k == 0) ? FIRST_TIMEOUT : BYTE_TIMEOUT, b, ok);
      if (!ok)
        break;
      got_q.push_back(b);
    end
  endtask

  // Line must stay idle and spi_ss high when asked
  task automatic watch_quiet(input int cycles, input bit ss_too);
    bit line_seen;
    bit ss_seen;
    int n;
    line_seen = 1'b0;
    ss_seen   = 1'b0;
    for (n = 0; n < cycles; n++)
    begin
      @(negedge CLK_200);
      if (uart_tx_line !== 1'b1 && !line_seen)
      begin
        line_seen = 1'b1;
        report_problem("a start bit appeared on uart_tx_line where no reply was expected");
      end
      if (ss_too && spi_ss !== 1'b1 && !ss_seen)
      begin
        ss_seen = 1'b1;
        report_problem("spi_ss went low although no SPI frame was expected");
      end
    end
  endtask

  task automatic compare_reply();
    int i;
    if (got_q.size() != exp_q.size())
      report_mismatch("reply length", 32'(got_q.size()), 32'(exp_q.size()));
    for (i = 0; i < got_q.size() && i < exp_q.size(); i++)
    begin
      if (got_q[i] !== exp_q[i])
        report_mismatch($sformatf("uart_tx_line byte %0d", i), 32'(got_q[i]), 32'(exp_q[i]));
    end
  endtask

  // ==============================
  // Command and reply builders
  // ==============================
  task automatic build_write(input logic [6:0] addr, input logic [7:0] data, input bit bad);
    logic [15:0] crc;
    crc = ref_crc16({8'h55, 8'h01, 1'b0, addr, data}, 4);
    if (bad)
      crc = crc ^ 16'h0001;  // One flipped bit
    cmd_q = '{8'h55, 8'h01, {1'b0, addr}, data, crc[15:8], crc[7:0]};
  endtask

  task automatic build_read(input logic [6:0] addr);
    logic [15:0] crc;
    crc   = ref_crc16({8'h00, 8'h55, 8'h02, 1'b0, addr}, 3);
    cmd_q = '{8'h55, 8'h02, {1'b0, addr}, crc[15:8], crc[7:0]};
  endtask

  task automatic expect_ack(input logic [7:0] data);
    logic [15:0] crc;
    crc   = ref_crc16({16'h0000, 8'hAA, data}, 2);
    exp_q = '{8'hAA, data, crc[15:8], crc[7:0]};
  endtask

  task automatic expect_version();
    int i;
    exp_q.delete();
    for (i = 0; i < 12; i++)
      exp_q.push_back(VERSION_ID[8 * (11 - i) +: 8]);
  endtask

  task automatic run_exchange(input int n_reply);
    fork
      send_command();
      receive_reply(n_reply);
    join
    compare_reply();
    watch_quiet(BYTE_TIMEOUT, 1'b0);  // No trailing bytes
  endtask

  task automatic run_silent();
    int window;
    window = cmd_q.size() * 10 * BIT_CLKS + QUIET_CLKS;
    fork
      send_command();
      watch_quiet(window, 1'b1);
    join
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial
  begin
    logic [6:0] addr;
    logic [7:0] data;
    int         k;
    int         r;
    glbl_rst     = 1'b1;
    uart_rx_line = 1'b1;
    rng          = SEED;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    err_base     = 0;
    for (k = 0; k < 128; k++)
    begin
      shadow[k]  = k[7:0] ^ 8'h5A;
      written[k] = 1'b0;
    end
    repeat (2) @(posedge CLK_200);
    glbl_rst <= 1'b0;

    @(negedge CLK_200);
    if (uart_tx_line !== 1'b1)
      report_mismatch("uart_tx_line", 32'(uart_tx_line), 32'd1);
    if (spi_ss !== 1'b1)
      report_mismatch("spi_ss", 32'(spi_ss), 32'd1);
    if (spi_clk !== 1'b0)
      report_mismatch("spi_clk", 32'(spi_clk), 32'd0);
    if (spi_mosi !== 1'b0)
      report_mismatch("spi_mosi", 32'(spi_mosi), 32'd0);
    if (crc_err !== 1'b0)
      report_mismatch("crc_err", 32'(crc_err), 32'd0);
    finish_test("reset state");

    cmd_q = '{8'h11};
    expect_version();
    run_exchange(12);
    finish_test("version request");

    for (r = 0; r < 3; r++)
    begin
      rng  = xorshift32(rng);
      addr = rng[6:0];
      data = rng[15:8];
      build_write(addr, data, 1'b0);
      expect_ack(8'h00);
      run_exchange(4);
      shadow[addr]  = data;
      written[addr] = 1'b1;
      build_read(addr);
      expect_ack(shadow[addr]);
      run_exchange(4);
      if (crc_err !== 1'b0)
        report_mismatch("crc_err", 32'(crc_err), 32'd0);
      finish_test($sformatf("write/read round %0d", r));
    end

    // Pick an address that no write has touched
    rng  = xorshift32(rng);
    addr = rng[6:0];
    for (k = 0; k < 128 && written[addr]; k++)
      addr = addr + 7'd1;
    build_read(addr);
    expect_ack({1'b0, addr} ^ 8'h5A);
    run_exchange(4);
    finish_test("unwritten read");

    rng  = xorshift32(rng);
    addr = rng[6:0];
    data = rng[23:16];
    if (data == shadow[addr])
      data = ~data;  // Must differ from the stored value
    build_write(addr, data, 1'b1);
    run_silent();
    if (crc_err !== 1'b1)
      report_mismatch("crc_err", 32'(crc_err), 32'd1);
    build_read(addr);
    expect_ack(shadow[addr]);  // Bad write must not land
    run_exchange(4);
    if (crc_err !== 1'b0)
      report_mismatch("crc_err", 32'(crc_err), 32'd0);
    finish_test("bad crc");

    cmd_q = '{8'h3C, 8'h55, 8'h07};
    run_silent();
    cmd_q = '{8'h11};
    expect_version();
    run_exchange(12);
    finish_test("unknown input");

    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

//--- sources.f
gnss_fe_pkg.sv
uart_rx.sv
uart_tx.sv
spi_master.sv
fe_cmd_ctrl.sv
reply_sender.sv
gnss_fe_top.sv
tb_frontend_models.sv
tb_gnss_fe.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
  --top-module tb_gnss_fe -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build returned an error"
  exit 1
fi

out="$(./obj_dir/Vtb_gnss_fe)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
